/* sim.f */
source/trap_pkg.sv
source/trap_csr_if.sv
source/trap_manager.sv
source/irq_controller.sv
source/trap_cause_reg.sv
source/apb_trap_regs.sv
source/trap_top.sv
test/trap_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module trap_tb -o trap_sim \
    && ./obj_dir/trap_sim > sim.log 2>&1 \
    || echo "build or simulation run did not complete"

cat sim.log 2>/dev/null

grep -qx "TEST PASSED" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

/* test/trap_tb.sv */
`timescale 1ns/1ps

module trap_tb;

    localparam int          CLK_PERIOD      = 4;
    localparam int          RESET_CYCLES    = 8;
    // Six tests of about 40 cycles each plus plenty of margin on top
    localparam int          WATCHDOG_CYCLES = 400;
    localparam logic [31:0] SEED            = 32'h9a55_326f;

    logic                            clk;
    logic                            rst_n;
    logic [trap_pkg::NUM_IRQ-1:0]    irq_lines;
    logic                            exception;
    logic [trap_pkg::EXC_CODE_W-1:0] exc_code;
    logic [trap_pkg::XLEN-1:0]       trap_pc;
    logic                            core_sleep;
    logic [trap_pkg::APB_ADDR_W-1:0] paddr;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [trap_pkg::XLEN-1:0]       pwdata;
    logic [trap_pkg::XLEN-1:0]       prdata;
    logic                            pready;
    logic                            pslverr;
    logic                            flush;
    logic                            stall;
    logic                            int_ack;
    logic [trap_pkg::XLEN-1:0]       handler_pc;

    int          err_count;
    int          pass_tests;
    int          fail_tests;
    // Vector base as software last programmed it with the low two bits cleared
    logic [31:0] base_model;

    trap_top trap_top_inst (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .irq_lines_i  (irq_lines),
        .exception_i  (exception),
        .exc_code_i   (exc_code),
        .trap_pc_i    (trap_pc),
        .core_sleep_i (core_sleep),
        .paddr_i      (paddr),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .flush_o      (flush),
        .stall_o      (stall),
        .int_ack_o    (int_ack),
        .handler_pc_o (handler_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // Checking and bookkeeping
    // ----------------------------------------------------------------------

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errs);
        if (err_count == start_errs) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d mismatches", name, err_count - start_errs);
        end
    endtask

    // Cause word of an interrupt has the flag on top and the index below
    function automatic logic [31:0] int_cause_word(input int idx);
        int_cause_word = (32'h1 << trap_pkg::CAUSE_INT_BIT) | 32'(idx);
    endfunction

    // Vectored mode places one word per interrupt line after the base
    function automatic logic [31:0] handler_for(input int idx);
        handler_for = base_model + 32'(idx * 4);
    endfunction

    // ----------------------------------------------------------------------
    // APB master
    // ----------------------------------------------------------------------

    // Setup phase and access phase are followed by an idle bus on the next negedge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                                input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        check_bit("pslverr_o", exp_err, err);
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_bit("pslverr_o", 1'b0, err);
        check_word(name, exp, data);
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_reset_state();
        int start_errs;
        start_errs = err_count;
        #1;
        check_bit("flush_o", 1'b0, flush);
        check_bit("stall_o", 1'b0, stall);
        check_bit("int_ack_o", 1'b0, int_ack);
        check_bit("pslverr_o", 1'b0, pslverr);
        check_bit("pready_o", 1'b1, pready);
        check_word("handler_pc_o", 32'h0, handler_pc);
        read_expect("prdata_o(IRQ_ENABLE)", trap_pkg::REG_IRQ_ENABLE, 32'h0);
        read_expect("prdata_o(IRQ_PENDING)", trap_pkg::REG_IRQ_PENDING, 32'h0);
        read_expect("prdata_o(VECTOR_BASE)", trap_pkg::REG_VECTOR_BASE, 32'h0);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, 32'h0);
        read_expect("prdata_o(EPC)", trap_pkg::REG_EPC, 32'h0);
        finish_test("reset_state", start_errs);
    endtask

    task automatic test_register_access();
        int          start_errs;
        logic [7:0]  mask;
        logic [31:0] base;
        logic [31:0] data;
        logic        err;
        start_errs = err_count;
        mask = 8'($urandom());
        base = $urandom();
        write_expect(trap_pkg::REG_IRQ_ENABLE, 32'(mask), 1'b0);
        write_expect(trap_pkg::REG_VECTOR_BASE, base, 1'b0);
        base_model = base & 32'hFFFF_FFFC;
        read_expect("prdata_o(IRQ_ENABLE)", trap_pkg::REG_IRQ_ENABLE, 32'(mask));
        read_expect("prdata_o(VECTOR_BASE)", trap_pkg::REG_VECTOR_BASE, base_model);
        // Unmapped offset answers with an error and zero data
        apb_read(8'h14, data, err);
        check_bit("pslverr_o", 1'b1, err);
        check_word("prdata_o(0x14)", 32'h0, data);
        // A write to the read-only CAUSE must bounce and change nothing
        write_expect(trap_pkg::REG_CAUSE, $urandom(), 1'b1);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, 32'h0);
        finish_test("register_access", start_errs);
    endtask

    task automatic test_exception();
        int                              start_errs;
        logic [31:0]                     pc;
        logic [trap_pkg::EXC_CODE_W-1:0] code;
        start_errs = err_count;
        pc   = $urandom();
        code = trap_pkg::EXC_CODE_W'($urandom());
        @(negedge clk);
        exception = 1'b1;
        exc_code  = code;
        trap_pc   = pc;
        #1;
        check_bit("flush_o", 1'b1, flush);
        check_bit("int_ack_o", 1'b0, int_ack);
        @(negedge clk);
        exception = 1'b0;
        #1;
        check_bit("flush_o", 1'b0, flush);
        check_bit("int_ack_o", 1'b0, int_ack);
        check_word("handler_pc_o", base_model, handler_pc);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, 32'(code));
        read_expect("prdata_o(EPC)", trap_pkg::REG_EPC, pc);
        finish_test("exception", start_errs);
    endtask

    task automatic test_interrupt_priority();
        int          start_errs;
        logic [31:0] pc_first;
        logic [31:0] pc_second;
        start_errs = err_count;
        pc_first  = $urandom();
        pc_second = $urandom();
        write_expect(trap_pkg::REG_IRQ_ENABLE, 32'h24, 1'b0);
        // One cycle pulse on lines 5 and 2 leaves both pending bits set
        irq_lines = 8'h24;
        trap_pc   = pc_first;
        @(negedge clk);
        irq_lines = '0;
        #1;
        check_bit("flush_o", 1'b1, flush);
        check_bit("int_ack_o", 1'b0, int_ack);
        // Line 5 is still pending and a second trap follows straight away
        // The PENDING read is overlapped with the two traps by hand
        @(negedge clk);
        paddr   = trap_pkg::REG_IRQ_PENDING;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        #1;
        check_bit("int_ack_o", 1'b1, int_ack);
        check_bit("flush_o", 1'b0, flush);
        @(negedge clk);
        penable = 1'b1;
        trap_pc = pc_second;
        #1;
        check_word("prdata_o(IRQ_PENDING)", 32'h20, prdata);
        check_bit("pslverr_o", 1'b0, pslverr);
        // Entry of line 2 shows that index 2 won the first acknowledge
        check_word("handler_pc_o", handler_for(2), handler_pc);
        check_bit("flush_o", 1'b1, flush);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        #1;
        check_bit("int_ack_o", 1'b1, int_ack);
        @(negedge clk);
        #1;
        check_word("handler_pc_o", handler_for(5), handler_pc);
        check_bit("int_ack_o", 1'b0, int_ack);
        check_bit("flush_o", 1'b0, flush);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, int_cause_word(5));
        read_expect("prdata_o(EPC)", trap_pkg::REG_EPC, pc_second);
        read_expect("prdata_o(IRQ_PENDING)", trap_pkg::REG_IRQ_PENDING, 32'h0);
        finish_test("interrupt_priority", start_errs);
    endtask

    task automatic test_masking();
        int                              start_errs;
        logic [31:0]                     pc;
        logic [trap_pkg::EXC_CODE_W-1:0] code;
        start_errs = err_count;
        pc   = $urandom();
        code = trap_pkg::EXC_CODE_W'($urandom());
        // Only line 4 is enabled so line 3 pends without raising a request
        write_expect(trap_pkg::REG_IRQ_ENABLE, 32'h10, 1'b0);
        irq_lines = 8'h08;
        @(negedge clk);
        irq_lines = '0;
        exception = 1'b1;
        exc_code  = code;
        trap_pc   = pc;
        #1;
        check_bit("flush_o", 1'b1, flush);
        check_bit("int_ack_o", 1'b0, int_ack);
        @(negedge clk);
        exception = 1'b0;
        #1;
        check_bit("int_ack_o", 1'b0, int_ack);
        check_word("handler_pc_o", base_model, handler_pc);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, 32'(code));
        read_expect("prdata_o(IRQ_PENDING)", trap_pkg::REG_IRQ_PENDING, 32'h08);
        // Enabled line 4 meets an exception in the same cycle
        pc        = $urandom();
        irq_lines = 8'h10;
        @(negedge clk);
        irq_lines = '0;
        exception = 1'b1;
        trap_pc   = pc;
        #1;
        check_bit("flush_o", 1'b1, flush);
        check_bit("int_ack_o", 1'b0, int_ack);
        @(negedge clk);
        exception = 1'b0;
        #1;
        check_bit("int_ack_o", 1'b1, int_ack);
        @(negedge clk);
        #1;
        check_word("handler_pc_o", handler_for(4), handler_pc);
        check_bit("int_ack_o", 1'b0, int_ack);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, int_cause_word(4));
        read_expect("prdata_o(EPC)", trap_pkg::REG_EPC, pc);
        finish_test("masking", start_errs);
    endtask

    task automatic test_sleep_wake();
        int          start_errs;
        logic [31:0] pc;
        start_errs = err_count;
        pc = $urandom();
        @(negedge clk);
        trap_pc    = pc;
        core_sleep = 1'b1;
        // Masked line 6 must not wake the core
        irq_lines  = 8'h40;
        #1;
        check_bit("stall_o", 1'b1, stall);
        check_bit("flush_o", 1'b0, flush);
        repeat (5) begin
            @(negedge clk);
            #1;
            check_bit("stall_o", 1'b1, stall);
            check_bit("flush_o", 1'b0, flush);
            check_bit("int_ack_o", 1'b0, int_ack);
        end
        @(negedge clk);
        irq_lines  = '0;
        core_sleep = 1'b0;
        #1;
        check_bit("stall_o", 1'b1, stall);
        // Opening the mask turns the sticky bit 6 into a wake-up request
        write_expect(trap_pkg::REG_IRQ_ENABLE, 32'h40, 1'b0);
        #1;
        check_bit("stall_o", 1'b0, stall);
        check_bit("flush_o", 1'b1, flush);
        @(negedge clk);
        #1;
        check_bit("int_ack_o", 1'b1, int_ack);
        check_bit("stall_o", 1'b0, stall);
        @(negedge clk);
        #1;
        check_bit("int_ack_o", 1'b0, int_ack);
        check_word("handler_pc_o", handler_for(6), handler_pc);
        read_expect("prdata_o(CAUSE)", trap_pkg::REG_CAUSE, int_cause_word(6));
        read_expect("prdata_o(EPC)", trap_pkg::REG_EPC, pc);
        finish_test("sleep_wake", start_errs);
    endtask

    // ----------------------------------------------------------------------
    // Sequence and watchdog
    // ----------------------------------------------------------------------

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        irq_lines  = '0;
        exception  = 1'b0;
        exc_code   = '0;
        trap_pc    = '0;
        core_sleep = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        err_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        base_model = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_register_access();
        test_exception();
        test_interrupt_priority();
        test_masking();
        test_sleep_wake();
        $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in %0d clock periods",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule : trap_tb

/* source/trap_top.sv */
`timescale 1ns/1ps

module trap_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Core side
    input  logic [trap_pkg::NUM_IRQ-1:0]    irq_lines_i,
    input  logic                            exception_i,
    input  logic [trap_pkg::EXC_CODE_W-1:0] exc_code_i,
    input  logic [trap_pkg::XLEN-1:0]       trap_pc_i,
    input  logic                            core_sleep_i,

    // APB slave
    input  logic [trap_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [trap_pkg::XLEN-1:0]       pwdata_i,
    output logic [trap_pkg::XLEN-1:0]       prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    // Pipeline control
    output logic                            flush_o,
    output logic                            stall_o,
    output logic                            int_ack_o,
    output logic [trap_pkg::XLEN-1:0]       handler_pc_o
);

    logic                           interrupt;
    logic                           exc_commit;
    logic [trap_pkg::IRQ_IDX_W-1:0] ack_index;

    trap_csr_if csr_if ();

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    trap_manager trap_manager_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .interrupt_i  (interrupt),
        .exception_i  (exception_i),
        .core_sleep_i (core_sleep_i),
        .flush_o      (flush_o),
        .stall_o      (stall_o),
        .int_ack_o    (int_ack_o),
        .exc_commit_o (exc_commit)
    );

    // ----------------------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------------------

    irq_controller irq_controller_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .irq_lines_i (irq_lines_i),
        .int_ack_i   (int_ack_o),
        .interrupt_o (interrupt),
        .ack_index_o (ack_index),
        .csr         (csr_if.irq_mp)
    );

    trap_cause_reg trap_cause_reg_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .int_ack_i    (int_ack_o),
        .exc_commit_i (exc_commit),
        .ack_index_i  (ack_index),
        .exc_code_i   (exc_code_i),
        .trap_pc_i    (trap_pc_i),
        .handler_pc_o (handler_pc_o),
        .csr          (csr_if.cause_mp)
    );

    apb_trap_regs apb_trap_regs_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .csr       (csr_if.regs_mp)
    );

endmodule : trap_top

/* source/apb_trap_regs.sv */
`timescale 1ns/1ps

module apb_trap_regs (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // APB slave
    input  logic [trap_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [trap_pkg::XLEN-1:0]       pwdata_i,
    output logic [trap_pkg::XLEN-1:0]       prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    trap_csr_if.regs_mp                     csr
);

    logic                         access;
    logic                         addr_valid;
    logic                         addr_ro;
    logic                         wr_en;
    logic [trap_pkg::NUM_IRQ-1:0] enable_q;
    logic [trap_pkg::XLEN-1:0]    base_q;
    logic [trap_pkg::XLEN-1:0]    rd_mux;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------

    // Only the access phase does anything, the setup phase is ignored
    assign access = psel_i & penable_i;

    always_comb begin
        addr_valid = 1'b1;
        addr_ro    = 1'b0;
        rd_mux     = '0;
        case (paddr_i)
            trap_pkg::REG_IRQ_ENABLE:  rd_mux = trap_pkg::XLEN'(enable_q);
            trap_pkg::REG_VECTOR_BASE: rd_mux = base_q;
            trap_pkg::REG_IRQ_PENDING: begin
                rd_mux  = trap_pkg::XLEN'(csr.pending);
                addr_ro = 1'b1;
            end
            trap_pkg::REG_CAUSE: begin
                rd_mux  = csr.cause;
                addr_ro = 1'b1;
            end
            trap_pkg::REG_EPC: begin
                rd_mux  = csr.epc;
                addr_ro = 1'b1;
            end
            default: addr_valid = 1'b0;
        endcase
    end

    // Unknown offsets and writes to read-only registers both fail
    assign pslverr_o = access & (~addr_valid | (pwrite_i & addr_ro));
    assign wr_en     = access & pwrite_i & ~pslverr_o;

    // Read data is zero outside a read access and for unknown offsets
    assign prdata_o  = (access && !pwrite_i) ? rd_mux : '0;

    // No wait states
    assign pready_o  = 1'b1;

    // ----------------------------------------------------------------------
    // Writable registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= '0;
            base_q   <= '0;
        end else if (wr_en) begin
            if (paddr_i == trap_pkg::REG_IRQ_ENABLE) begin
                enable_q <= pwdata_i[trap_pkg::NUM_IRQ-1:0];
            end
            // Handlers are word aligned so the two low bits never stick
            if (paddr_i == trap_pkg::REG_VECTOR_BASE) begin
                base_q <= {pwdata_i[trap_pkg::XLEN-1:2], 2'b00};
            end
        end
    end

    assign csr.enable_mask = enable_q;
    assign csr.vector_base = base_q;

endmodule : apb_trap_regs

/* source/trap_cause_reg.sv */
`timescale 1ns/1ps

module trap_cause_reg (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Trap taken in this cycle
    input  logic                            int_ack_i,
    input  logic                            exc_commit_i,

    // What was taken and where
    input  logic [trap_pkg::IRQ_IDX_W-1:0]  ack_index_i,
    input  logic [trap_pkg::EXC_CODE_W-1:0] exc_code_i,
    input  logic [trap_pkg::XLEN-1:0]       trap_pc_i,

    // Address the core jumps to
    output logic [trap_pkg::XLEN-1:0]       handler_pc_o,

    trap_csr_if.cause_mp                    csr
);

    logic [trap_pkg::XLEN-1:0] int_cause;
    logic [trap_pkg::XLEN-1:0] exc_cause;
    logic [trap_pkg::XLEN-1:0] int_handler;

    // Interrupt cause carries the index with the interrupt flag on top
    always_comb begin
        int_cause = trap_pkg::XLEN'(ack_index_i);
        int_cause[trap_pkg::CAUSE_INT_BIT] = 1'b1;
    end

    // Exception cause is the bare code with the interrupt flag clear
    assign exc_cause = trap_pkg::XLEN'(exc_code_i);

    // Vectored mode places one word per interrupt line after the base
    assign int_handler = csr.vector_base + trap_pkg::XLEN'({ack_index_i, 2'b00});

    // ----------------------------------------------------------------------
    // Trap record
    // ----------------------------------------------------------------------

    // The manager never asserts both strobes together
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            csr.cause    <= '0;
            csr.epc      <= '0;
            handler_pc_o <= '0;
        end else if (int_ack_i) begin
            csr.cause    <= int_cause;
            csr.epc      <= trap_pc_i;
            handler_pc_o <= int_handler;
        end else if (exc_commit_i) begin
            csr.cause    <= exc_cause;
            csr.epc      <= trap_pc_i;
            // All exceptions share the entry at the base itself
            handler_pc_o <= csr.vector_base;
        end
    end

endmodule : trap_cause_reg

/* source/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Level-sampled interrupt lines
    input  logic [trap_pkg::NUM_IRQ-1:0]   irq_lines_i,

    // Acknowledge from the trap manager
    input  logic                           int_ack_i,

    // Request and winning index
    output logic                           interrupt_o,
    output logic [trap_pkg::IRQ_IDX_W-1:0] ack_index_o,

    trap_csr_if.irq_mp                     csr
);

    logic [trap_pkg::NUM_IRQ-1:0] pending_q;
    logic [trap_pkg::NUM_IRQ-1:0] masked;
    logic [trap_pkg::NUM_IRQ-1:0] clear_mask;

    // ----------------------------------------------------------------------
    // Priority encoder
    // ----------------------------------------------------------------------

    assign masked      = pending_q & csr.enable_mask;
    assign interrupt_o = |masked;

    // Scanning from the top down leaves the lowest set index as the winner
    always_comb begin
        ack_index_o = '0;
        for (int i = trap_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (masked[i]) begin
                ack_index_o = trap_pkg::IRQ_IDX_W'(i);
            end
        end
    end

    // One-hot of the bit being acknowledged and empty when nothing is taken
    always_comb begin
        clear_mask = '0;
        if (int_ack_i && interrupt_o) begin
            clear_mask = trap_pkg::NUM_IRQ'(1) << ack_index_o;
        end
    end

    // ----------------------------------------------------------------------
    // Sticky pending bits
    // ----------------------------------------------------------------------

    // The acknowledge clears its bit at this edge while other lines still set theirs
    // A line that is still high sets the acknowledged bit again on the next edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q | irq_lines_i) & ~clear_mask;
        end
    end

    assign csr.pending = pending_q;

endmodule : irq_controller

/* source/trap_manager.sv */
`timescale 1ns/1ps

module trap_manager (
    input  logic clk_i,
    input  logic rst_n_i,

    // Events from the core and the interrupt controller
    input  logic interrupt_i,
    input  logic exception_i,
    input  logic core_sleep_i,

    // Pipeline control
    output logic flush_o,
    output logic stall_o,
    output logic int_ack_o,
    output logic exc_commit_o
);

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        ACK_CYCLE,
        WAIT_WAKE_UP
    } state_t;

    state_t state_q, state_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Next state and outputs
    // ----------------------------------------------------------------------

    always_comb begin
        state_d      = state_q;
        flush_o      = 1'b0;
        stall_o      = 1'b0;
        int_ack_o    = 1'b0;
        exc_commit_o = 1'b0;

        case (state_q)
            // Interrupts win over exceptions and over a sleep request
            IDLE: begin
                if (interrupt_i) begin
                    // Flush now and acknowledge in the following cycle
                    state_d = ACK_CYCLE;
                end else if (core_sleep_i) begin
                    state_d = WAIT_WAKE_UP;
                end
                flush_o      = interrupt_i | exception_i;
                // An exception is only taken when no interrupt is competing
                exc_commit_o = exception_i & ~interrupt_i;
                stall_o      = core_sleep_i & ~interrupt_i;
            end

            // Single acknowledge cycle, the handler fetch is already under way
            ACK_CYCLE: begin
                int_ack_o = 1'b1;
                state_d   = IDLE;
            end

            // The core stays frozen until an enabled interrupt shows up
            WAIT_WAKE_UP: begin
                stall_o = 1'b1;
                if (interrupt_i) begin
                    stall_o = 1'b0;
                    flush_o = 1'b1;
                    state_d = ACK_CYCLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule : trap_manager

/* source/trap_csr_if.sv */
`timescale 1ns/1ps

// Register values shared between the APB block and the datapath blocks
interface trap_csr_if;

    // Programmed by software through the APB block
    logic [trap_pkg::NUM_IRQ-1:0] enable_mask;
    logic [trap_pkg::XLEN-1:0]    vector_base;

    // Live state of the interrupt controller
    logic [trap_pkg::NUM_IRQ-1:0] pending;

    // Trap record kept by the cause register
    logic [trap_pkg::XLEN-1:0]    cause;
    logic [trap_pkg::XLEN-1:0]    epc;

    // The APB block owns the control registers and reads everything back
    modport regs_mp (output enable_mask, output vector_base,
                     input pending, input cause, input epc);

    // The interrupt controller needs the mask and reports its pending bits
    modport irq_mp (input enable_mask, output pending);

    // The cause register builds handler addresses from the vector base
    modport cause_mp (input vector_base, output cause, output epc);

endinterface : trap_csr_if

/* source/trap_pkg.sv */
package trap_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------

    // Number of interrupt lines and the width of an index into them
    localparam int NUM_IRQ    = 8;
    localparam int IRQ_IDX_W  = 3;

    // Data and address width of the core
    localparam int XLEN       = 32;

    // Width of the exception code delivered by the pipeline
    localparam int EXC_CODE_W = 4;

    // APB address width of the register block
    localparam int APB_ADDR_W = 8;

    // ----------------------------------------------------------------------
    // Register map
    // ----------------------------------------------------------------------

    localparam logic [APB_ADDR_W-1:0] REG_IRQ_ENABLE  = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_IRQ_PENDING = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_VECTOR_BASE = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_CAUSE       = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_EPC         = 8'h10;

    // Set in the cause word for an interrupt and clear for an exception
    // The low bits then hold the interrupt index or the exception code
    localparam int CAUSE_INT_BIT = 31;

endpackage : trap_pkg
